// ==== design/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data and address width
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// architectural registers including x0
`define NREGS 32

// run length limit, in cycles per instruction
`define CYCLE_FACTOR 2

`endif

// ==== design/rv_isa_pkg.sv ====
`include "rv_consts.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`XLEN-1:0] addr_t;
  typedef logic [$clog2(`NREGS)-1:0] reg_idx_t;
  typedef logic [31:0] instr_t;

  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_e;

  // encodings follow funct3, none sits in a hole
  typedef enum logic [2:0] {
    bcu_beq  = 3'b000,
    bcu_bne  = 3'b001,
    bcu_none = 3'b010,
    bcu_blt  = 3'b100,
    bcu_bge  = 3'b101,
    bcu_bltu = 3'b110,
    bcu_bgeu = 3'b111
  } bcu_op_e;

  // nine kinds, so one bit wider than funct3
  typedef enum logic [3:0] {
    lsu_none = 4'd0,
    lsu_lb   = 4'd1,
    lsu_lh   = 4'd2,
    lsu_lw   = 4'd3,
    lsu_lbu  = 4'd4,
    lsu_lhu  = 4'd5,
    lsu_sb   = 4'd6,
    lsu_sh   = 4'd7,
    lsu_sw   = 4'd8
  } lsu_op_e;

endpackage

// ==== design/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

  typedef struct packed {
    logic                valid;
    rv_isa_pkg::word_t   imm;
    logic                wren;
    logic                rden1;
    logic                rden2;
    logic                lui;
    logic                auipc;
    logic                jal;
    logic                jalr;
    logic                branch;
    logic                load;
    logic                store;
    rv_isa_pkg::bcu_op_e bcu_op;
    rv_isa_pkg::lsu_op_e lsu_op;
  } decode_t;

  typedef struct packed {
    logic              valid;
    rv_isa_pkg::addr_t addr;
  } imem_req_t;

  typedef struct packed {
    logic               valid;
    rv_isa_pkg::instr_t data;
  } imem_rsp_t;

  typedef struct packed {
    logic                 valid;
    rv_isa_pkg::reg_idx_t addr;
    rv_isa_pkg::word_t    data;
  } wb_t;

  typedef struct packed {
    rv_isa_pkg::addr_t address;
    logic [3:0]        byteenable;
    logic              exception;
  } agu_out_t;

  typedef struct packed {
    logic                 valid;
    rv_isa_pkg::addr_t    pc;
    rv_isa_pkg::instr_t   instr;
    rv_isa_pkg::word_t    imm;
    rv_isa_pkg::word_t    rdata1;
    rv_isa_pkg::word_t    rdata2;
    rv_isa_pkg::reg_idx_t waddr;
    logic                 wren;
    logic                 jump;
    logic                 load;
    logic                 store;
    rv_isa_pkg::lsu_op_e  lsu_op;
    rv_isa_pkg::addr_t    address;
    logic                 exception;
  } fetch_packet_t;

  typedef struct packed {
    logic              valid;
    rv_isa_pkg::addr_t addr;
    rv_isa_pkg::word_t wdata;
    logic [3:0]        wstrb;
  } dmem_req_t;

endpackage

// ==== design/predecoder.sv ====
`timescale 1ns/1ps

module predecoder (
  input  rv_isa_pkg::instr_t   instr,
  output rv_pipe_pkg::decode_t dec
);

  logic [2:0]        funct3;
  rv_isa_pkg::word_t imm_i;
  rv_isa_pkg::word_t imm_s;
  rv_isa_pkg::word_t imm_b;
  rv_isa_pkg::word_t imm_u;
  rv_isa_pkg::word_t imm_j;

  always_comb begin
    funct3 = instr[14:12];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u = {instr[31:12], 12'b0};
    imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    dec = '0;
    dec.bcu_op = rv_isa_pkg::bcu_none;
    dec.lsu_op = rv_isa_pkg::lsu_none;

    case (instr[6:0])
      rv_isa_pkg::opc_lui: begin
        dec.valid = 1'b1;
        dec.wren = 1'b1;
        dec.lui = 1'b1;
        dec.imm = imm_u;
      end
      rv_isa_pkg::opc_auipc: begin
        dec.valid = 1'b1;
        dec.wren = 1'b1;
        dec.auipc = 1'b1;
        dec.imm = imm_u;
      end
      rv_isa_pkg::opc_jal: begin
        dec.valid = 1'b1;
        dec.wren = 1'b1;
        dec.jal = 1'b1;
        dec.imm = imm_j;
      end
      rv_isa_pkg::opc_jalr: begin
        if (funct3 == 3'b000) begin
          dec.valid = 1'b1;
          dec.wren = 1'b1;
          dec.rden1 = 1'b1;
          dec.jalr = 1'b1;
          dec.imm = imm_i;
        end
      end
      rv_isa_pkg::opc_branch: begin
        if (funct3[2:1] != 2'b01) begin // 010 and 011 are reserved
          dec.valid = 1'b1;
          dec.rden1 = 1'b1;
          dec.rden2 = 1'b1;
          dec.branch = 1'b1;
          dec.bcu_op = rv_isa_pkg::bcu_op_e'(funct3);
          dec.imm = imm_b;
        end
      end
      rv_isa_pkg::opc_load: begin
        case (funct3)
          3'b000: dec.lsu_op = rv_isa_pkg::lsu_lb;
          3'b001: dec.lsu_op = rv_isa_pkg::lsu_lh;
          3'b010: dec.lsu_op = rv_isa_pkg::lsu_lw;
          3'b100: dec.lsu_op = rv_isa_pkg::lsu_lbu;
          3'b101: dec.lsu_op = rv_isa_pkg::lsu_lhu;
          default: dec.lsu_op = rv_isa_pkg::lsu_none;
        endcase
        if (dec.lsu_op != rv_isa_pkg::lsu_none) begin
          dec.valid = 1'b1;
          dec.wren = 1'b1;
          dec.rden1 = 1'b1;
          dec.load = 1'b1;
          dec.imm = imm_i;
        end
      end
      rv_isa_pkg::opc_store: begin
        case (funct3)
          3'b000: dec.lsu_op = rv_isa_pkg::lsu_sb;
          3'b001: dec.lsu_op = rv_isa_pkg::lsu_sh;
          3'b010: dec.lsu_op = rv_isa_pkg::lsu_sw;
          default: dec.lsu_op = rv_isa_pkg::lsu_none;
        endcase
        if (dec.lsu_op != rv_isa_pkg::lsu_none) begin
          dec.valid = 1'b1;
          dec.rden1 = 1'b1;
          dec.rden2 = 1'b1;
          dec.store = 1'b1;
          dec.imm = imm_s;
        end
      end
      rv_isa_pkg::opc_op_imm: begin
        dec.valid = 1'b1;
        dec.wren = 1'b1;
        dec.rden1 = 1'b1;
        dec.imm = imm_i;
      end
      rv_isa_pkg::opc_op: begin
        dec.valid = 1'b1;
        dec.wren = 1'b1;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== design/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
  input  rv_isa_pkg::word_t   rdata1,
  input  rv_isa_pkg::word_t   rdata2,
  input  rv_isa_pkg::bcu_op_e bcu_op,
  output logic                taken
);

  always_comb begin
    case (bcu_op)
      rv_isa_pkg::bcu_beq:  taken = (rdata1 == rdata2);
      rv_isa_pkg::bcu_bne:  taken = (rdata1 != rdata2);
      rv_isa_pkg::bcu_blt:  taken = ($signed(rdata1) < $signed(rdata2));
      rv_isa_pkg::bcu_bge:  taken = ($signed(rdata1) >= $signed(rdata2));
      rv_isa_pkg::bcu_bltu: taken = (rdata1 < rdata2);
      rv_isa_pkg::bcu_bgeu: taken = (rdata1 >= rdata2);
      default:              taken = 1'b0; // not a branch
    endcase
  end

endmodule

// ==== design/addr_gen.sv ====
`timescale 1ns/1ps

module addr_gen (
  input  rv_isa_pkg::addr_t     pc,
  input  rv_isa_pkg::word_t     rdata1,
  input  rv_isa_pkg::word_t     imm,
  input  logic                  jal,
  input  logic                  jalr,
  input  logic                  branch,
  input  logic                  load,
  input  logic                  store,
  input  rv_isa_pkg::lsu_op_e   lsu_op,
  output rv_pipe_pkg::agu_out_t agu
);

  rv_isa_pkg::addr_t sum;
  logic              misaligned;

  always_comb begin
    sum = (jalr | load | store) ? rdata1 + imm : pc + imm;
    agu.address = jalr ? (sum & ~rv_isa_pkg::addr_t'(1)) : sum;

    case (lsu_op)
      rv_isa_pkg::lsu_lb, rv_isa_pkg::lsu_lbu, rv_isa_pkg::lsu_sb: begin
        agu.byteenable = 4'b0001 << agu.address[1:0];
        misaligned = 1'b0;
      end
      rv_isa_pkg::lsu_lh, rv_isa_pkg::lsu_lhu, rv_isa_pkg::lsu_sh: begin
        agu.byteenable = 4'b0011 << agu.address[1:0];
        misaligned = agu.address[0];
      end
      rv_isa_pkg::lsu_lw, rv_isa_pkg::lsu_sw: begin
        agu.byteenable = 4'b1111;
        misaligned = (agu.address[1:0] != 2'b00);
      end
      default: begin
        agu.byteenable = 4'b0000;
        misaligned = 1'b0;
      end
    endcase

    // jump targets must be word aligned, no compressed support
    agu.exception = ((load | store) & misaligned) |
                    ((jal | jalr | branch) & (agu.address[1:0] != 2'b00));
  end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_isa_pkg::reg_idx_t raddr1,
  input  rv_isa_pkg::reg_idx_t raddr2,
  input  rv_pipe_pkg::wb_t     wb,
  output rv_isa_pkg::word_t    rdata1,
  output rv_isa_pkg::word_t    rdata2
);

  rv_isa_pkg::word_t regs [1:`NREGS-1]; // no storage for x0

  function automatic rv_isa_pkg::word_t read_port(input rv_isa_pkg::reg_idx_t raddr);
    if (raddr == '0) begin
      return '0;
    end else if (wb.valid && wb.addr == raddr) begin
      return wb.data; // same cycle write wins
    end
    return regs[raddr];
  endfunction

  always_comb begin
    rdata1 = read_port(raddr1);
    rdata2 = read_port(raddr2);
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 1; i < `NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.addr != '0) begin
      regs[wb.addr] <= wb.data;
    end
  end

endmodule

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module fetch_stage (
  input  logic                       clk,
  input  logic                       rst,
  output rv_pipe_pkg::imem_req_t     imem_req,
  input  rv_pipe_pkg::imem_rsp_t     imem_rsp,
  input  rv_pipe_pkg::decode_t       dec,
  output rv_isa_pkg::instr_t         instr,
  output rv_isa_pkg::addr_t          pc,
  output rv_isa_pkg::reg_idx_t       raddr1,
  output rv_isa_pkg::reg_idx_t       raddr2,
  input  rv_isa_pkg::word_t          rdata1,
  input  rv_isa_pkg::word_t          rdata2,
  input  logic                       taken,
  input  rv_pipe_pkg::agu_out_t      agu,
  output rv_pipe_pkg::fetch_packet_t packet,
  output rv_pipe_pkg::dmem_req_t     dmem
);

  typedef struct packed {
    logic                       req_valid;
    rv_isa_pkg::addr_t          pc;      // request on the bus now
    rv_isa_pkg::addr_t          fly_pc;  // request answered this cycle
    logic                       spec;    // drop this cycle's answer
    rv_pipe_pkg::fetch_packet_t packet;
    rv_pipe_pkg::dmem_req_t     dmem;
  } fetch_reg_t;

  fetch_reg_t r;
  fetch_reg_t v;
  logic       live;
  logic       jump;
  logic       load;
  logic       store;
  logic       wren;
  logic       exception;

  assign instr = imem_rsp.data;
  assign pc = r.fly_pc;
  assign raddr1 = dec.rden1 ? instr[19:15] : '0;
  assign raddr2 = dec.rden2 ? instr[24:20] : '0;

  always_comb begin
    v = r;

    live = imem_rsp.valid & ~r.spec;
    jump = dec.jal | dec.jalr | (dec.branch & taken);
    load = dec.load;
    store = dec.store;
    wren = dec.wren;
    exception = agu.exception;

    // the faulting action is suppressed, nothing else
    if (exception) begin
      if (load) begin
        load = 1'b0;
        wren = 1'b0;
      end else if (store) begin
        store = 1'b0;
      end else if (jump) begin
        jump = 1'b0;
        wren = 1'b0;
      end else begin
        exception = 1'b0; // untaken branch to a bad target
      end
    end

    v.req_valid = 1'b1;
    v.fly_pc = r.pc;
    v.spec = 1'b0;
    if (r.req_valid) begin
      v.pc = r.pc + rv_isa_pkg::addr_t'(4);
    end
    if (live && jump) begin
      v.pc = agu.address;
      v.spec = 1'b1; // sequential fetch on the bus is stale
    end

    v.packet.valid = live;
    v.packet.pc = r.fly_pc;
    v.packet.instr = instr;
    v.packet.imm = dec.imm;
    v.packet.rdata1 = rdata1;
    v.packet.rdata2 = rdata2;
    v.packet.waddr = instr[11:7];
    v.packet.wren = wren;
    v.packet.jump = jump;
    v.packet.load = load;
    v.packet.store = store;
    v.packet.lsu_op = dec.lsu_op;
    v.packet.address = agu.address;
    v.packet.exception = exception;

    v.dmem.valid = live & (load | store);
    v.dmem.addr = agu.address;
    case (dec.lsu_op)
      rv_isa_pkg::lsu_sb: v.dmem.wdata = {4{rdata2[7:0]}};
      rv_isa_pkg::lsu_sh: v.dmem.wdata = {2{rdata2[15:0]}};
      default:            v.dmem.wdata = rdata2;
    endcase
    v.dmem.wstrb = store ? agu.byteenable : 4'b0000;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      r <= '0;
      r.pc <= `RESET_PC;
    end else begin
      r <= v;
    end
  end

  assign imem_req.valid = r.req_valid;
  assign imem_req.addr = r.pc;
  assign packet = r.packet;
  assign dmem = r.dmem;

endmodule

// ==== design/front_end.sv ====
`timescale 1ns/1ps

module front_end (
  input  logic                       clk,
  input  logic                       rst,
  output rv_pipe_pkg::imem_req_t     imem_req,
  input  rv_pipe_pkg::imem_rsp_t     imem_rsp,
  input  rv_pipe_pkg::wb_t           wb,
  output rv_pipe_pkg::fetch_packet_t packet,
  output rv_pipe_pkg::dmem_req_t     dmem
);

  rv_pipe_pkg::decode_t  dec;
  rv_pipe_pkg::agu_out_t agu;
  rv_isa_pkg::instr_t    instr;
  rv_isa_pkg::addr_t     pc;
  rv_isa_pkg::reg_idx_t  raddr1;
  rv_isa_pkg::reg_idx_t  raddr2;
  rv_isa_pkg::word_t     rdata1;
  rv_isa_pkg::word_t     rdata2;
  logic                  taken;

  fetch_stage i_fetch_stage (
    .clk      (clk),
    .rst      (rst),
    .imem_req (imem_req),
    .imem_rsp (imem_rsp),
    .dec      (dec),
    .instr    (instr),
    .pc       (pc),
    .raddr1   (raddr1),
    .raddr2   (raddr2),
    .rdata1   (rdata1),
    .rdata2   (rdata2),
    .taken    (taken),
    .agu      (agu),
    .packet   (packet),
    .dmem     (dmem)
  );

  predecoder i_predecoder (
    .instr (instr),
    .dec   (dec)
  );

  reg_file i_reg_file (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .wb     (wb),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  branch_unit i_branch_unit (
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .bcu_op (dec.bcu_op),
    .taken  (taken)
  );

  addr_gen i_addr_gen (
    .pc     (pc),
    .rdata1 (rdata1),
    .imm    (dec.imm),
    .jal    (dec.jal),
    .jalr   (dec.jalr),
    .branch (dec.branch),
    .load   (dec.load),
    .store  (dec.store),
    .lsu_op (dec.lsu_op),
    .agu    (agu)
  );

endmodule

// ==== bench/front_end_assert.sv ====
`timescale 1ns/1ps

module front_end_assert (
  input logic                       clk,
  input logic                       rst,
  input rv_pipe_pkg::imem_req_t     imem_req,
  input rv_pipe_pkg::imem_rsp_t     imem_rsp,
  input rv_pipe_pkg::fetch_packet_t packet,
  input rv_pipe_pkg::dmem_req_t     dmem
);

  packet_after_rsp: assert property (@(posedge clk) disable iff (!rst)
    packet.valid |-> $past(imem_rsp.valid))
    else $error("packet valid without a response one cycle earlier");

  // faulting accesses never reach data memory
  dmem_with_packet: assert property (@(posedge clk) disable iff (!rst)
    dmem.valid |-> (packet.valid && !packet.exception))
    else $error("dmem request without a clean packet");

  req_stays_high: assert property (@(posedge clk) disable iff (!rst)
    $past(imem_req.valid) |-> imem_req.valid)
    else $error("fetch request dropped after it started");

endmodule

bind front_end front_end_assert i_front_end_assert (
  .clk      (clk),
  .rst      (rst),
  .imem_req (imem_req),
  .imem_rsp (imem_rsp),
  .packet   (packet),
  .dmem     (dmem)
);

// ==== bench/front_end_tb.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module front_end_tb;

  localparam int NUM_INSTR = 600;
  localparam int CYCLE_LIMIT = `CYCLE_FACTOR * NUM_INSTR + 50;
  localparam int TABLE_WORDS = 256;

  logic                       clk;
  logic                       rst;
  rv_pipe_pkg::imem_req_t     imem_req;
  rv_pipe_pkg::imem_rsp_t     imem_rsp;
  rv_pipe_pkg::wb_t           wb;
  rv_pipe_pkg::fetch_packet_t packet;
  rv_pipe_pkg::dmem_req_t     dmem;

  int                         seed;
  rv_isa_pkg::instr_t         imem [0:TABLE_WORDS-1];
  rv_isa_pkg::word_t          shadow [0:`NREGS-1];
  rv_isa_pkg::addr_t          req_addr; // expected address on the bus
  rv_isa_pkg::addr_t          fly_addr; // address of the answer now on imem_rsp
  logic                       spec;
  logic                       req_on;   // fetch expected on the bus
  rv_pipe_pkg::fetch_packet_t exp_pkt;
  rv_pipe_pkg::dmem_req_t     exp_dmem;
  int                         cycles;
  int                         checked;
  int                         errors;

  front_end i_dut (
    .clk      (clk),
    .rst      (rst),
    .imem_req (imem_req),
    .imem_rsp (imem_rsp),
    .wb       (wb),
    .packet   (packet),
    .dmem     (dmem)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_packet(input rv_pipe_pkg::fetch_packet_t got,
                              input rv_pipe_pkg::fetch_packet_t exp);
    if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
      errors++;
      $display("mismatch at %0t: packet got %h expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_dmem(input rv_pipe_pkg::dmem_req_t got,
                            input rv_pipe_pkg::dmem_req_t exp);
    if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
      errors++;
      $display("mismatch at %0t: dmem got %h expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input rv_isa_pkg::addr_t got, input rv_isa_pkg::addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: imem_req.addr got %h expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_req_valid(input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: imem_req.valid got %b expected %b", $time, got, exp);
      abort_run();
    end
  endtask

  // folds the whole address into the table
  function automatic logic [7:0] table_index(input rv_isa_pkg::addr_t a);
    return a[9:2] ^ a[17:10] ^ a[25:18] ^ {2'b00, a[31:26]};
  endfunction

  function automatic rv_isa_pkg::instr_t random_instr();
    rv_isa_pkg::instr_t w;
    logic [31:0]        sel;
    logic [2:0]         f3;
    w = $random(seed);
    sel = $random(seed);
    f3 = (sel[5:4] == 2'b11) ? 3'b010 : {1'b0, sel[5:4]}; // lb/lh/lw, sb/sh/sw
    case (sel[3:0])
      4'd0, 4'd1: begin
        w[6:0] = rv_isa_pkg::opc_op_imm;
        w[14:12] = 3'b000;
      end
      4'd2, 4'd3: begin
        w[6:0] = rv_isa_pkg::opc_op;
        w[14:12] = 3'b000;
        w[31:25] = 7'b0000000;
      end
      4'd4: w[6:0] = rv_isa_pkg::opc_lui;
      4'd5: w[6:0] = rv_isa_pkg::opc_auipc;
      4'd6: begin
        w[6:0] = rv_isa_pkg::opc_jal;
        if (sel[8]) w[21] = 1'b0; // imm[1]
      end
      4'd7: begin
        w[6:0] = rv_isa_pkg::opc_jalr;
        w[14:12] = 3'b000;
        if (sel[8]) w[21:20] = 2'b00;
      end
      4'd8, 4'd9: begin
        w[6:0] = rv_isa_pkg::opc_branch;
        w[14:12] = sel[6:4];
        if (sel[6:5] == 2'b01) w[14] = 1'b1; // skip reserved funct3
        if (sel[8]) w[8] = 1'b0;
      end
      4'd10, 4'd11, 4'd12: begin
        w[6:0] = rv_isa_pkg::opc_load;
        w[14:12] = f3;
        if (sel[8]) w[21:20] = 2'b00;
      end
      default: begin
        w[6:0] = rv_isa_pkg::opc_store;
        w[14:12] = f3;
        if (sel[8]) w[8:7] = 2'b00;
      end
    endcase
    return w;
  endfunction

  // expected result from the RV32I rules with the same-cycle write already in shadow
  function automatic void predict(input rv_isa_pkg::instr_t instr, input rv_isa_pkg::addr_t pc,
                                  output rv_pipe_pkg::fetch_packet_t pkt,
                                  output rv_pipe_pkg::dmem_req_t dm,
                                  output rv_isa_pkg::addr_t next);
    rv_isa_pkg::word_t imm;
    rv_isa_pkg::word_t s1;
    rv_isa_pkg::word_t s2;
    rv_isa_pkg::addr_t a;
    logic [2:0]        f3;
    logic              use1;
    logic              use2;
    logic              take;
    logic              bad;
    logic [3:0]        mask;
    f3 = instr[14:12];
    imm = '0;
    use1 = 1'b0;
    use2 = 1'b0;
    take = 1'b0;
    pkt = '0;
    pkt.valid = 1'b1;
    pkt.pc = pc;
    pkt.instr = instr;
    pkt.waddr = instr[11:7];
    pkt.lsu_op = rv_isa_pkg::lsu_none;
    case (instr[6:0])
      rv_isa_pkg::opc_lui, rv_isa_pkg::opc_auipc: begin
        imm = {instr[31:12], 12'h000};
        pkt.wren = 1'b1;
      end
      rv_isa_pkg::opc_jal: begin
        imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        pkt.wren = 1'b1;
        take = 1'b1;
      end
      rv_isa_pkg::opc_jalr: begin
        imm = {{20{instr[31]}}, instr[31:20]};
        use1 = 1'b1;
        pkt.wren = 1'b1;
        take = 1'b1;
      end
      rv_isa_pkg::opc_branch: begin
        imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        use1 = 1'b1;
        use2 = 1'b1;
      end
      rv_isa_pkg::opc_load: begin
        imm = {{20{instr[31]}}, instr[31:20]};
        use1 = 1'b1;
        pkt.wren = 1'b1;
        pkt.load = 1'b1;
        case (f3)
          3'b000: pkt.lsu_op = rv_isa_pkg::lsu_lb;
          3'b001: pkt.lsu_op = rv_isa_pkg::lsu_lh;
          default: pkt.lsu_op = rv_isa_pkg::lsu_lw;
        endcase
      end
      rv_isa_pkg::opc_store: begin
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        use1 = 1'b1;
        use2 = 1'b1;
        pkt.store = 1'b1;
        case (f3)
          3'b000: pkt.lsu_op = rv_isa_pkg::lsu_sb;
          3'b001: pkt.lsu_op = rv_isa_pkg::lsu_sh;
          default: pkt.lsu_op = rv_isa_pkg::lsu_sw;
        endcase
      end
      rv_isa_pkg::opc_op_imm: begin
        imm = {{20{instr[31]}}, instr[31:20]};
        use1 = 1'b1;
        pkt.wren = 1'b1;
      end
      default: begin // register-register op
        use1 = 1'b1;
        use2 = 1'b1;
        pkt.wren = 1'b1;
      end
    endcase

    s1 = use1 ? shadow[instr[19:15]] : '0;
    s2 = use2 ? shadow[instr[24:20]] : '0;
    if (instr[6:0] == rv_isa_pkg::opc_branch) begin
      case (f3)
        3'b000: take = (s1 == s2);
        3'b001: take = (s1 != s2);
        3'b100: take = ($signed(s1) < $signed(s2));
        3'b101: take = ($signed(s1) >= $signed(s2));
        3'b110: take = (s1 < s2);
        default: take = (s1 >= s2);
      endcase
    end

    a = (use1 && instr[6:0] != rv_isa_pkg::opc_branch && instr[6:0] != rv_isa_pkg::opc_op &&
         instr[6:0] != rv_isa_pkg::opc_op_imm) ? s1 + imm : pc + imm;
    if (instr[6:0] == rv_isa_pkg::opc_jalr) a[0] = 1'b0;

    case (f3[1:0])
      2'b00: mask = 4'b0001 << a[1:0];
      2'b01: mask = 4'b0011 << a[1:0];
      default: mask = 4'b1111;
    endcase
    if (pkt.load || pkt.store) begin
      bad = (f3[1:0] == 2'b01) ? a[0] : (f3[1:0] == 2'b10) ? (a[1:0] != 2'b00) : 1'b0;
    end else begin
      bad = take && (a[1:0] != 2'b00); // untaken branches never fault
    end

    pkt.imm = imm;
    pkt.rdata1 = s1;
    pkt.rdata2 = s2;
    pkt.address = a;
    pkt.jump = take && !bad;
    if (bad) begin
      pkt.exception = 1'b1;
      if (pkt.load || take) pkt.wren = 1'b0;
      pkt.load = 1'b0;
      pkt.store = 1'b0;
    end

    dm = '0;
    dm.valid = pkt.load || pkt.store;
    dm.addr = a;
    case (f3[1:0])
      2'b00: dm.wdata = {4{s2[7:0]}};
      2'b01: dm.wdata = {2{s2[15:0]}};
      default: dm.wdata = s2;
    endcase
    dm.wstrb = pkt.store ? mask : 4'b0000;
    next = pkt.jump ? a : pc + 32'd4;
  endfunction

  // instruction memory answers one cycle after each request
  always @(posedge clk) begin : imem_model
    if (!rst) begin
      imem_rsp <= '0;
    end else begin
      imem_rsp.valid <= imem_req.valid;
      imem_rsp.data <= imem[table_index(imem_req.addr)];
    end
  end

  always @(posedge clk) begin : wb_driver
    logic [31:0]       rnd;
    rv_isa_pkg::word_t d;
    if (!rst) begin
      wb <= '0;
    end else begin
      rnd = $random(seed);
      d = $random(seed);
      if (rnd[8]) d[1:0] = 2'b00; // aligned base now and then
      wb.valid <= rnd[0];
      wb.addr <= rnd[5:1];
      wb.data <= d;
    end
  end

  // outputs seen here were registered at the previous edge
  always @(posedge clk) begin : compare
    logic              live;
    rv_isa_pkg::addr_t next;
    if (rst) begin
      cycles++;
      check_packet(packet, exp_pkt);
      check_dmem(dmem, exp_dmem);
      if (exp_pkt.valid) checked++;
      check_req_valid(imem_req.valid, req_on);
      if (req_on) check_addr(imem_req.addr, req_addr);

      if (wb.valid && wb.addr != '0) shadow[wb.addr] = wb.data;

      live = imem_rsp.valid && !spec;
      exp_pkt = '0;
      exp_dmem = '0;
      next = req_addr + 32'd4;
      if (live) predict(imem_rsp.data, fly_addr, exp_pkt, exp_dmem, next);
      fly_addr = req_addr;
      if (req_on) begin
        req_addr = (live && exp_pkt.jump) ? next : req_addr + 32'd4;
      end
      spec = live && exp_pkt.jump; // in-flight answer is stale
      req_on = 1'b1; // one idle cycle after reset, then a fetch every cycle
    end
  end

  initial begin
    seed = 32'h84b9;
    rst = 1'b0;
    imem_rsp = '0;
    wb = '0;
    req_addr = `RESET_PC;
    fly_addr = `RESET_PC;
    spec = 1'b0;
    req_on = 1'b0;
    exp_pkt = '0;
    exp_dmem = '0;
    cycles = 0;
    checked = 0;
    errors = 0;
    for (int i = 0; i < `NREGS; i++) begin
      shadow[i] = '0;
    end
    for (int i = 0; i < TABLE_WORDS; i++) begin
      imem[i] = random_instr();
    end

    repeat (8) @(posedge clk);
    rst <= 1'b1;

    while (checked < NUM_INSTR && cycles < CYCLE_LIMIT) begin
      @(negedge clk);
    end
    if (checked < NUM_INSTR) begin
      $display("timeout: only %0d of %0d instructions checked in %0d cycles",
               checked, NUM_INSTR, cycles);
      abort_run();
    end else if (errors == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

// ==== vlog.f ====
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/predecoder.sv
design/branch_unit.sv
design/addr_gen.sv
design/reg_file.sv
design/fetch_stage.sv
design/front_end.sv
bench/front_end_assert.sv
bench/front_end_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= front_end_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
BIN  := $(OBJ_DIR)/$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
